/* compile.f */
+incdir+.
kt_grid_pkg.sv
kt_search_pkg.sv
kt_path_ram.sv
kt_board.sv
kt_tour_solver.sv
kt_top.sv
tb_kt_checker.sv
tb_kt.sv

/* kt_board.sv */
`timescale 1ns/1ns
`include "kt_config.svh"

module kt_board (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_clear,
	input  logic                  i_mark,
	input  logic                  i_unmark,
	input  kt_grid_pkg::coord_t   i_cell_x,
	input  kt_grid_pkg::coord_t   i_cell_y,
	input  kt_grid_pkg::coord_t   i_cur_x,
	input  kt_grid_pkg::coord_t   i_cur_y,
	input  kt_search_pkg::dir_t   i_dir,
	output kt_grid_pkg::coord_t   o_tgt_x,
	output kt_grid_pkg::coord_t   o_tgt_y,
	output logic                  o_legal,
	output logic                  o_full
);
	import kt_grid_pkg::*;
	import kt_search_pkg::*;

	logic [`KT_CELLS-1:0] visited;  // bit 5*x+y set once the cell is on the path
	knight_off_t off;
	logic signed [`KT_COORD_W:0] sum_x, sum_y;  // one extra bit, range -2..6
	logic on_board;
	cell_idx_t tgt_idx;
	cell_idx_t cell_idx;  // cell being marked or unmarked

	// candidate target from the current cell
	assign off   = knight_offset(i_dir);
	assign sum_x = $signed({1'b0, i_cur_x}) + $signed(off.dx);
	assign sum_y = $signed({1'b0, i_cur_y}) + $signed(off.dy);

	assign on_board = (sum_x >= 0) && (sum_x < `KT_SIDE) &&
		(sum_y >= 0) && (sum_y < `KT_SIDE);

	assign o_tgt_x = sum_x[`KT_COORD_W-1:0];
	assign o_tgt_y = sum_y[`KT_COORD_W-1:0];
	assign tgt_idx = to_cell_idx(o_tgt_x, o_tgt_y);

	// off-board index is junk but the bound check masks it
	assign o_legal = on_board && !visited[tgt_idx];
	assign o_full  = &visited;

	assign cell_idx = to_cell_idx(i_cell_x, i_cell_y);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			visited <= '0;
		end else if (i_clear) begin
			visited <= '0;  // end of stream, ready for the next puzzle
		end else if (i_mark) begin
			visited[cell_idx] <= 1'b1;
		end else if (i_unmark) begin
			visited[cell_idx] <= 1'b0;  // backtrack
		end
	end

	// a repeated mark means the solver stepped onto its own path
	a_mark_fresh: assert property (@(posedge clk) disable iff (!rst_n)
		i_mark |-> !visited[cell_idx]);

	// unmark only ever removes the cell the solver last added
	a_unmark_set: assert property (@(posedge clk) disable iff (!rst_n)
		i_unmark |-> visited[cell_idx]);

	a_mark_xor_unmark: assert property (@(posedge clk) disable iff (!rst_n)
		!(i_mark && i_unmark));

endmodule

/* kt_config.svh */
`ifndef KT_CONFIG_SVH
`define KT_CONFIG_SVH

// board geometry
`define KT_SIDE    5   // cells per row and per column
`define KT_CELLS   25  // KT_SIDE squared
`define KT_DIRS    8   // knight move directions
`define KT_DIR_W   3   // bits for one direction

// widths for indexing
`define KT_STEP_W  5   // path position or move count, 0..25
`define KT_COORD_W 3   // single x or y coordinate

`endif

/* kt_grid_pkg.sv */
`include "kt_config.svh"

package kt_grid_pkg;

	// one board coordinate, x or y, 0..KT_SIDE-1
	typedef logic [`KT_COORD_W-1:0] coord_t;

	// flat cell number, 5*x + y
	typedef logic [`KT_STEP_W-1:0] cell_idx_t;

	// position along the path, or a move count for the output stream
	typedef logic [`KT_STEP_W-1:0] step_t;

	// row-major flattening used for the visited map
	function automatic cell_idx_t to_cell_idx(input coord_t x, input coord_t y);
		return cell_idx_t'(x * `KT_SIDE + y);
	endfunction

endpackage

/* kt_input.txt */
# case header: priority move_num stream_cycles
# then move_num lines of x y, the starting path in order
# corner start, runs into a dead end and backtracks
0 1 25
0 0
# six cell starting path
3 6 25
0 0
1 2
0 4
2 3
4 4
3 2
# centre start, last direction first
7 1 25
2 2

/* kt_path_ram.sv */
`timescale 1ns/1ns
`include "kt_config.svh"

module kt_path_ram (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_wr_en,
	input  kt_grid_pkg::step_t    i_wr_step,
	input  kt_grid_pkg::coord_t   i_wr_x,
	input  kt_grid_pkg::coord_t   i_wr_y,
	input  kt_search_pkg::dir_t   i_wr_dir,
	input  kt_grid_pkg::step_t    i_rd_step,
	output kt_grid_pkg::coord_t   o_rd_x,
	output kt_grid_pkg::coord_t   o_rd_y,
	output kt_search_pkg::dir_t   o_rd_dir
);
	import kt_grid_pkg::*;
	import kt_search_pkg::*;

	// entry k is path cell k and the direction taken from cell k-1 to get there
	coord_t mem_x   [`KT_CELLS];
	coord_t mem_y   [`KT_CELLS];
	dir_t   mem_dir [`KT_CELLS];  // don't care for cells of the starting path

	always_ff @(posedge clk) begin
		if (i_wr_en) begin
			mem_x[i_wr_step]   <= i_wr_x;
			mem_y[i_wr_step]   <= i_wr_y;
			mem_dir[i_wr_step] <= i_wr_dir;
		end
	end

	// async read, solver sees the entry in the same cycle
	assign o_rd_x   = mem_x[i_rd_step];
	assign o_rd_y   = mem_y[i_rd_step];
	assign o_rd_dir = mem_dir[i_rd_step];

	// solver must never step past the last cell of the tour
	a_wr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		i_wr_en |-> (i_wr_step < `KT_CELLS));

endmodule

/* kt_search_pkg.sv */
`include "kt_config.svh"

package kt_search_pkg;

	typedef logic [`KT_DIR_W-1:0] dir_t;  // 0..7, cyclic

	// solver phase
	typedef enum logic [1:0] {
		PH_IDLE   = 2'd0,  // waiting for in_valid
		PH_LOAD   = 2'd1,  // taking the rest of the starting path
		PH_SEARCH = 2'd2,  // dfs, one attempt or one backtrack per cycle
		PH_STREAM = 2'd3   // tour goes out one cell per cycle
	} phase_t;

	typedef logic signed [`KT_COORD_W-1:0] offset_t;  // -2..+2 fits in 3 bits

	typedef struct packed {
		offset_t dx;
		offset_t dy;
	} knight_off_t;

	// direction 0 points up-left and the rest go clockwise
	function automatic knight_off_t knight_offset(input dir_t d);
		case (d)
			3'd0: return '{dx: -1, dy:  2};
			3'd1: return '{dx:  1, dy:  2};
			3'd2: return '{dx:  2, dy:  1};
			3'd3: return '{dx:  2, dy: -1};
			3'd4: return '{dx:  1, dy: -2};
			3'd5: return '{dx: -1, dy: -2};
			3'd6: return '{dx: -2, dy: -1};
			3'd7: return '{dx: -2, dy:  1};
			default: return '{dx: 0, dy: 0};
		endcase
	endfunction

endpackage

/* kt_top.sv */
`timescale 1ns/1ns
`include "kt_config.svh"

module kt_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_in_valid,
	input  kt_grid_pkg::coord_t   i_in_x,
	input  kt_grid_pkg::coord_t   i_in_y,
	input  kt_grid_pkg::step_t    i_move_num,
	input  kt_search_pkg::dir_t   i_priority_num,
	output logic                  o_out_valid,
	output kt_grid_pkg::coord_t   o_out_x,
	output kt_grid_pkg::coord_t   o_out_y,
	output kt_grid_pkg::step_t    o_move_out
);
	import kt_grid_pkg::*;
	import kt_search_pkg::*;

	// solver <-> path ram
	logic   wr_en;
	step_t  wr_step;
	coord_t wr_x, wr_y;
	dir_t   wr_dir;
	step_t  rd_step;
	coord_t rd_x, rd_y;
	dir_t   rd_dir;

	// solver <-> board
	logic   clear, mark, unmark;
	coord_t cell_x, cell_y;
	coord_t cur_x, cur_y;
	dir_t   dir;
	coord_t tgt_x, tgt_y;
	logic   legal, full;

	kt_tour_solver u_solver (
		.clk(clk), .rst_n(rst_n),
		.i_in_valid(i_in_valid), .i_in_x(i_in_x), .i_in_y(i_in_y),
		.i_move_num(i_move_num), .i_priority_num(i_priority_num),
		.o_wr_en(wr_en), .o_wr_step(wr_step), .o_wr_x(wr_x), .o_wr_y(wr_y),
		.o_wr_dir(wr_dir), .o_rd_step(rd_step),
		.i_rd_x(rd_x), .i_rd_y(rd_y), .i_rd_dir(rd_dir),
		.o_clear(clear), .o_mark(mark), .o_unmark(unmark),
		.o_cell_x(cell_x), .o_cell_y(cell_y),
		.o_cur_x(cur_x), .o_cur_y(cur_y), .o_dir(dir),
		.i_tgt_x(tgt_x), .i_tgt_y(tgt_y), .i_legal(legal), .i_full(full),
		.o_out_valid(o_out_valid), .o_out_x(o_out_x), .o_out_y(o_out_y),
		.o_move_out(o_move_out)
	);

	kt_path_ram u_path_ram (
		.clk(clk), .rst_n(rst_n),
		.i_wr_en(wr_en), .i_wr_step(wr_step), .i_wr_x(wr_x), .i_wr_y(wr_y),
		.i_wr_dir(wr_dir), .i_rd_step(rd_step),
		.o_rd_x(rd_x), .o_rd_y(rd_y), .o_rd_dir(rd_dir)
	);

	kt_board u_board (
		.clk(clk), .rst_n(rst_n),
		.i_clear(clear), .i_mark(mark), .i_unmark(unmark),
		.i_cell_x(cell_x), .i_cell_y(cell_y),
		.i_cur_x(cur_x), .i_cur_y(cur_y), .i_dir(dir),
		.o_tgt_x(tgt_x), .o_tgt_y(tgt_y), .o_legal(legal), .o_full(full)
	);

endmodule

/* kt_tour_solver.sv */
`timescale 1ns/1ns
`include "kt_config.svh"

module kt_tour_solver (
	input  logic                  clk,
	input  logic                  rst_n,
	// puzzle input
	input  logic                  i_in_valid,
	input  kt_grid_pkg::coord_t   i_in_x,
	input  kt_grid_pkg::coord_t   i_in_y,
	input  kt_grid_pkg::step_t    i_move_num,
	input  kt_search_pkg::dir_t   i_priority_num,
	// path ram
	output logic                  o_wr_en,
	output kt_grid_pkg::step_t    o_wr_step,
	output kt_grid_pkg::coord_t   o_wr_x,
	output kt_grid_pkg::coord_t   o_wr_y,
	output kt_search_pkg::dir_t   o_wr_dir,
	output kt_grid_pkg::step_t    o_rd_step,
	input  kt_grid_pkg::coord_t   i_rd_x,
	input  kt_grid_pkg::coord_t   i_rd_y,
	input  kt_search_pkg::dir_t   i_rd_dir,
	// board
	output logic                  o_clear,
	output logic                  o_mark,
	output logic                  o_unmark,
	output kt_grid_pkg::coord_t   o_cell_x,
	output kt_grid_pkg::coord_t   o_cell_y,
	output kt_grid_pkg::coord_t   o_cur_x,
	output kt_grid_pkg::coord_t   o_cur_y,
	output kt_search_pkg::dir_t   o_dir,
	input  kt_grid_pkg::coord_t   i_tgt_x,
	input  kt_grid_pkg::coord_t   i_tgt_y,
	input  logic                  i_legal,
	input  logic                  i_full,
	// tour output
	output logic                  o_out_valid,
	output kt_grid_pkg::coord_t   o_out_x,
	output kt_grid_pkg::coord_t   o_out_y,
	output kt_grid_pkg::step_t    o_move_out
);
	import kt_grid_pkg::*;
	import kt_search_pkg::*;

	localparam logic [`KT_DIR_W:0] TRIED_ALL = `KT_DIRS;

	phase_t phase;
	step_t prefix_len;  // cells given by the starting path
	dir_t prio;         // first direction tried from every new cell
	step_t step;        // path index of the current cell
	dir_t dir;          // direction of this cycle's attempt
	logic [`KT_DIR_W:0] tried;  // directions already tried from the current cell, 0..8

	logic load_cell;    // input cell taken this cycle
	logic attempt;
	logic advance;      // attempt landed on a free cell
	logic backtrack;
	logic stream_last;  // last stream cycle, move_out at 25

	assign load_cell   = i_in_valid && (phase == PH_IDLE || phase == PH_LOAD);
	assign attempt     = (phase == PH_SEARCH) && !i_full && (tried != TRIED_ALL);
	assign advance     = attempt && i_legal;
	assign backtrack   = (phase == PH_SEARCH) && !i_full && (tried == TRIED_ALL);
	assign stream_last = (phase == PH_STREAM) && (o_move_out == step_t'(`KT_CELLS));

	// new cells come either from the input or from a legal move
	assign o_wr_en   = load_cell || advance;
	assign o_wr_step = (phase == PH_IDLE) ? '0 : step_t'(step + 1'b1);
	assign o_wr_x    = advance ? i_tgt_x : i_in_x;
	assign o_wr_y    = advance ? i_tgt_y : i_in_y;
	assign o_wr_dir  = advance ? dir : '0;

	// read port: current cell in search, next cell to show in stream
	always_comb begin
		case (phase)
			PH_SEARCH: o_rd_step = i_full ? '0 : step;  // full preloads cell 0
			PH_STREAM: o_rd_step = stream_last ? '0 : o_move_out;
			default:   o_rd_step = '0;
		endcase
	end

	// board follows the ram writes, unmark drops the current cell
	assign o_clear  = stream_last;
	assign o_mark   = o_wr_en;
	assign o_unmark = backtrack;
	assign o_cell_x = backtrack ? i_rd_x : o_wr_x;
	assign o_cell_y = backtrack ? i_rd_y : o_wr_y;
	assign o_cur_x  = i_rd_x;  // current cell lives in the ram only
	assign o_cur_y  = i_rd_y;
	assign o_dir    = dir;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase      <= PH_IDLE;
			prefix_len <= '0;
			prio       <= '0;
			step       <= '0;
			dir        <= '0;
			tried      <= '0;
		end else begin
			case (phase)
				PH_IDLE: begin
					if (i_in_valid) begin  // first cell goes to step 0
						prefix_len <= i_move_num;
						prio       <= i_priority_num;
						dir        <= i_priority_num;
						tried      <= '0;
						step       <= '0;
						phase      <= (i_move_num > step_t'(1)) ? PH_LOAD : PH_SEARCH;
					end
				end
				PH_LOAD: begin
					if (i_in_valid) begin
						step <= step_t'(step + 1'b1);
						if (step_t'(step + 2'd2) >= prefix_len)
							phase <= PH_SEARCH;  // last input cell
					end else begin
						phase <= PH_SEARCH;  // burst cut short
					end
				end
				PH_SEARCH: begin
					if (i_full) begin
						phase <= PH_STREAM;
					end else if (backtrack) begin
						// resume one past the direction that reached the dropped cell
						step  <= step_t'(step - 1'b1);
						dir   <= dir_t'(i_rd_dir + 1'b1);
						tried <= {1'b0, dir_t'(i_rd_dir - prio)} + 1'b1;
					end else if (i_legal) begin
						step  <= step_t'(step + 1'b1);
						dir   <= prio;
						tried <= '0;
					end else begin
						dir   <= dir_t'(dir + 1'b1);  // wraps 7 -> 0
						tried <= tried + 1'b1;
					end
				end
				PH_STREAM: begin
					if (stream_last)
						phase <= PH_IDLE;
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	// outputs registered, valid rises the cycle after full
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_out_valid <= 1'b0;
			o_out_x     <= '0;
			o_out_y     <= '0;
			o_move_out  <= '0;
		end else if (phase == PH_SEARCH && i_full) begin
			o_out_valid <= 1'b1;
			o_out_x     <= i_rd_x;  // cell 0
			o_out_y     <= i_rd_y;
			o_move_out  <= step_t'(1);
		end else if (phase == PH_STREAM) begin
			if (stream_last) begin
				o_out_valid <= 1'b0;
				o_out_x     <= '0;
				o_out_y     <= '0;
				o_move_out  <= '0;
			end else begin
				o_out_x    <= i_rd_x;
				o_out_y    <= i_rd_y;
				o_move_out <= step_t'(o_move_out + 1'b1);
			end
		end
	end

	a_valid_only_stream: assert property (@(posedge clk) disable iff (!rst_n)
		o_out_valid |-> (phase == PH_STREAM));

	// the starting path is never taken apart
	a_keep_prefix: assert property (@(posedge clk) disable iff (!rst_n)
		backtrack |-> (step >= prefix_len));

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the knight's tour testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module tb_kt -o tb_kt_sim \
	&& ./obj_dir/tb_kt_sim | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* tb_kt.sv */
`timescale 1ns/1ns
`include "kt_config.svh"

module tb_kt;
	import kt_grid_pkg::*;
	import kt_search_pkg::*;

	localparam int MAX_CASES   = 8;
	localparam int CASE_CYCLES = 200000;  // search budget for one puzzle
	localparam int TOT         = MAX_CASES * `KT_CELLS;

	logic   clk;
	logic   rst_n;
	logic   in_valid;
	coord_t in_x, in_y;
	step_t  move_num;
	dir_t   priority_num;
	logic   out_valid;
	coord_t out_x, out_y;
	step_t  move_out;

	int     n_cases;
	int     prio_tab [MAX_CASES];
	int     pre_len  [MAX_CASES];  // starting path length per case
	int     out_len  [MAX_CASES];  // expected stream cycles per case
	coord_t pre_x [TOT];
	coord_t pre_y [TOT];
	coord_t exp_x [TOT];           // expected tour, case*25 + step
	coord_t exp_y [TOT];
	int     errors;
	int     done_cases;
	int     setup_errors;
	int     backtracks;            // model backtrack steps over all cases
	logic   loaded;
	bit     ok;

	// knight offsets, direction 0..7 clockwise from (-1,+2)
	int off_x [8] = '{-1,  1,  2,  2,  1, -1, -2, -2};
	int off_y [8] = '{ 2,  2,  1, -1, -2, -2, -1,  1};

	kt_top UUT (
		.clk(clk), .rst_n(rst_n),
		.i_in_valid(in_valid), .i_in_x(in_x), .i_in_y(in_y),
		.i_move_num(move_num), .i_priority_num(priority_num),
		.o_out_valid(out_valid), .o_out_x(out_x), .o_out_y(out_y),
		.o_move_out(move_out)
	);

	tb_kt_checker #(.MAX_CASES(MAX_CASES)) u_checker (
		.clk(clk), .rst_n(rst_n),
		.i_out_valid(out_valid), .i_out_x(out_x), .i_out_y(out_y),
		.i_move_out(move_out),
		.i_pre_len(pre_len), .i_out_len(out_len),
		.i_pre_x(pre_x), .i_pre_y(pre_y), .i_exp_x(exp_x), .i_exp_y(exp_y),
		.o_errors(errors), .o_done(done_cases)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// next line that is neither a comment nor blank
	task automatic fetch_line(input int fd, output string line, output bit got);
		string s;
		int r;
		got  = 0;
		line = "";
		while (!got && !$feof(fd)) begin
			r = $fgets(s, fd);
			if (r > 0 && s.len() > 0 && s.getc(0) != 8'h23 && s.getc(0) != 8'h0a) begin
				line = s;
				got  = 1;
			end
		end
	endtask

	task automatic read_cases();
		int fd, r, p, l, o, x, y;
		string line;
		bit got;
		n_cases = 0;
		fd = $fopen("kt_input.txt", "r");
		if (fd == 0) begin
			$display("could not open kt_input.txt");
			setup_errors++;
			return;
		end
		got = 1;
		while (got && n_cases < MAX_CASES) begin
			fetch_line(fd, line, got);
			if (!got)
				break;
			r = $sscanf(line, "%d %d %d", p, l, o);
			if (r != 3 || l < 1 || l > `KT_CELLS) begin
				$display("bad case header in kt_input.txt: %s", line);
				setup_errors++;
				break;
			end
			prio_tab[n_cases] = p;
			pre_len[n_cases]  = l;
			out_len[n_cases]  = o;
			for (int k = 0; k < l; k++) begin
				fetch_line(fd, line, got);
				r = $sscanf(line, "%d %d", x, y);
				if (!got || r != 2) begin
					$display("starting path of case %0d is cut short", n_cases);
					setup_errors++;
				end
				pre_x[n_cases*`KT_CELLS + k] = coord_t'(x);
				pre_y[n_cases*`KT_CELLS + k] = coord_t'(y);
			end
			n_cases++;
		end
		$fclose(fd);
	endtask

	// depth first tour search, fills the expected tour of case c
	task automatic solve_case(input int c, output bit found);
		int px [25];
		int py [25];
		int pd [25];  // direction that reached each cell
		bit seen [25];
		int n, d, tried, tx, ty, pr, base;
		base  = c * `KT_CELLS;
		pr    = prio_tab[c];
		found = 1;
		for (int k = 0; k < 25; k++)
			seen[k] = 0;
		for (int k = 0; k < pre_len[c]; k++) begin
			px[k] = int'(pre_x[base+k]);
			py[k] = int'(pre_y[base+k]);
			seen[px[k]*5 + py[k]] = 1;
		end
		n     = pre_len[c];
		d     = pr;
		tried = 0;
		while (n < 25 && found) begin
			if (tried < 8) begin
				tx = px[n-1] + off_x[d];
				ty = py[n-1] + off_y[d];
				if (tx >= 0 && tx < 5 && ty >= 0 && ty < 5 && !seen[tx*5 + ty]) begin
					px[n] = tx;
					py[n] = ty;
					pd[n] = d;
					seen[tx*5 + ty] = 1;
					n++;
					d     = pr;
					tried = 0;
				end else begin
					d = (d + 1) % 8;
					tried++;
				end
			end else if (n <= pre_len[c]) begin
				found = 0;  // would have to drop a given cell
			end else begin
				n--;
				seen[px[n]*5 + py[n]] = 0;
				d     = (pd[n] + 1) % 8;
				tried = ((pd[n] - pr + 8) % 8) + 1;
				backtracks++;
			end
		end
		if (found) begin
			for (int k = 0; k < 25; k++) begin
				exp_x[base+k] = coord_t'(px[k]);
				exp_y[base+k] = coord_t'(py[k]);
			end
		end
	endtask

	// one burst, move_num and priority only on the first beat
	task automatic drive_case(input int c);
		int base;
		base = c * `KT_CELLS;
		@(posedge clk);
		#2;
		for (int k = 0; k < pre_len[c]; k++) begin
			in_valid     = 1'b1;
			in_x         = pre_x[base+k];
			in_y         = pre_y[base+k];
			move_num     = (k == 0) ? step_t'(pre_len[c]) : '0;
			priority_num = (k == 0) ? dir_t'(prio_tab[c]) : '0;
			@(posedge clk);
			#2;
		end
		in_valid     = 1'b0;
		in_x         = '0;
		in_y         = '0;
		move_num     = '0;
		priority_num = '0;
	endtask

	initial begin
		rst_n        = 1'b0;
		in_valid     = 1'b0;
		in_x         = '0;
		in_y         = '0;
		move_num     = '0;
		priority_num = '0;
		loaded       = 1'b0;
		setup_errors = 0;
		backtracks   = 0;
		read_cases();
		for (int c = 0; c < n_cases; c++) begin
			solve_case(c, ok);
			if (!ok) begin
				$display("case %0d has no tour from its starting path", c);
				setup_errors++;
			end
		end
		if (n_cases > 0 && backtracks == 0) begin
			$display("no case needs a backtrack, so backtracking goes untested");
			setup_errors++;
		end
		loaded = 1'b1;
		repeat (2) @(posedge clk);
		#2 rst_n = 1'b1;
		if (setup_errors == 0) begin
			for (int c = 0; c < n_cases; c++) begin
				drive_case(c);
				while (done_cases < c + 1)  // checker bumps this when the stream ends
					@(posedge clk);
			end
		end
		repeat (5) @(posedge clk);
		$display("errors %0d, setup errors %0d, cases done %0d of %0d",
			errors, setup_errors, done_cases, n_cases);
		if (errors == 0 && setup_errors == 0 && n_cases > 0 && done_cases == n_cases) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// watchdog, budget grows with the number of cases
	initial begin
		wait (loaded);
		repeat ((n_cases + 1) * CASE_CYCLES) @(posedge clk);
		$display("watchdog expired at %0t, the search never finished", $time);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* tb_kt_checker.sv */
`timescale 1ns/1ns
`include "kt_config.svh"

module tb_kt_checker #(
	parameter int MAX_CASES = 8
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_out_valid,
	input  kt_grid_pkg::coord_t  i_out_x,
	input  kt_grid_pkg::coord_t  i_out_y,
	input  kt_grid_pkg::step_t   i_move_out,
	input  int                   i_pre_len [MAX_CASES],
	input  int                   i_out_len [MAX_CASES],
	input  kt_grid_pkg::coord_t  i_pre_x [MAX_CASES*`KT_CELLS],
	input  kt_grid_pkg::coord_t  i_pre_y [MAX_CASES*`KT_CELLS],
	input  kt_grid_pkg::coord_t  i_exp_x [MAX_CASES*`KT_CELLS],
	input  kt_grid_pkg::coord_t  i_exp_y [MAX_CASES*`KT_CELLS],
	output int                   o_errors,
	output int                   o_done
);
	import kt_grid_pkg::*;

	int     cnt;        // stream beats seen in this case
	int     base;
	int     idx;
	int     cx, cy;
	bit [24:0] seen;    // cells already streamed
	int     last_x, last_y;

	task automatic report(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		o_errors++;
	endtask

	function automatic bit knight_step(input int ax, input int ay, input int bx, input int by);
		int dx, dy;
		dx = (ax > bx) ? ax - bx : bx - ax;
		dy = (ay > by) ? ay - by : by - ay;
		return (dx == 1 && dy == 2) || (dx == 2 && dy == 1);
	endfunction

	// sampled mid cycle, outputs are registered on the rising edge
	always @(negedge clk) begin
		if (!rst_n) begin
			cnt      = 0;
			seen     = '0;
			o_errors = 0;
			o_done   = 0;
		end else if (i_out_valid) begin
			cnt++;
			cx   = int'(i_out_x);
			cy   = int'(i_out_y);
			idx  = cnt - 1;
			base = o_done * `KT_CELLS;
			if (o_done >= MAX_CASES) begin
				report("stream with no puzzle pending");
			end else begin
				if (int'(i_move_out) != cnt)
					report($sformatf("move_out %0d, expected %0d", i_move_out, cnt));
				if (cnt > i_out_len[o_done]) begin
					report($sformatf("out_valid held past %0d cycles", i_out_len[o_done]));
				end else begin
					if (idx < i_pre_len[o_done] &&
						(i_out_x != i_pre_x[base+idx] || i_out_y != i_pre_y[base+idx]))
						report($sformatf("cell %0d (%0d,%0d) is not starting path cell (%0d,%0d)",
							idx, cx, cy, i_pre_x[base+idx], i_pre_y[base+idx]));
					if (i_out_x != i_exp_x[base+idx] || i_out_y != i_exp_y[base+idx])
						report($sformatf("case %0d cell %0d is (%0d,%0d), expected (%0d,%0d)",
							o_done, idx, cx, cy, i_exp_x[base+idx], i_exp_y[base+idx]));
				end
				if (cx > 4 || cy > 4) begin
					report($sformatf("cell (%0d,%0d) off the board", cx, cy));
				end else begin
					if (seen[cx*5 + cy])
						report($sformatf("cell (%0d,%0d) repeats", cx, cy));
					seen[cx*5 + cy] = 1'b1;
				end
				if (cnt > 1 && !knight_step(last_x, last_y, cx, cy))
					report($sformatf("(%0d,%0d) to (%0d,%0d) is no knight move",
						last_x, last_y, cx, cy));
			end
			last_x = cx;
			last_y = cy;
		end else begin
			// idle outputs must be all zero
			if (i_out_x != '0 || i_out_y != '0 || i_move_out != '0)
				report("outputs not zero while out_valid is low");
			if (cnt > 0) begin  // stream just ended
				if (o_done < MAX_CASES && cnt != i_out_len[o_done])
					report($sformatf("stream lasted %0d cycles, expected %0d",
						cnt, i_out_len[o_done]));
				o_done++;
				cnt  = 0;
				seen = '0;
			end
		end
	end

endmodule
